//--- Makefile
TOP := tb_trigger_fft
LOG := sim.log

all: run

obj_dir/V$(TOP): trigger_fft.f $(wildcard *.sv)
	verilator --binary --timing --assert -j 0 -f trigger_fft.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f trigger_fft.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

//--- dft_engine.sv
// sequential 16-point DFT: twiddle multiply, accumulate per bin, |re|+|im| magnitude out
`timescale 1ns/1ps

module dft_engine import trigger_fft_types_pkg::*; (
  input  logic         clk,
  input  logic         reset_b,
  input  sample_beat_t beat,
  output bin_result_t  result
);

  localparam int ACC_W = $bits(acc_t);

  bin_idx_t pos_q;       // sample position of the previous beat
  bin_idx_t pos_d;
  logic [7:0] kn;        // bin x position, full width
  bin_idx_t tw_idx;
  prod_t    re_prod_d;
  prod_t    im_prod_d;
  prod_t    re_prod_q;
  prod_t    im_prod_q;
  logic     s1_vld_q;
  logic     s1_first_q;
  logic     s1_last_q;
  bin_idx_t s1_bin_q;
  acc_t     re_acc_q;
  acc_t     im_acc_q;
  acc_t     re_acc_d;
  acc_t     im_acc_d;
  logic     res_vld_q;
  bin_idx_t res_bin_q;
  mag_t     res_mag_q;

  // (|re| + |im|) >> 7, clipped to 16 bits
  function automatic mag_t abs_sum_mag(input acc_t re, input acc_t im);
    logic [ACC_W-1:0] abs_re;
    logic [ACC_W-1:0] abs_im;
    logic [ACC_W:0]   sum;
    logic [ACC_W-7:0] scaled;
    abs_re = re[ACC_W-1] ? ACC_W'(-re) : ACC_W'(re);
    abs_im = im[ACC_W-1] ? ACC_W'(-im) : ACC_W'(im);
    sum    = abs_re + abs_im;  // carry kept
    scaled = sum[ACC_W:7];
    if (|scaled[ACC_W-7:16]) begin
      return '1;  // saturate
    end
    return scaled[15:0];
  endfunction

  // stage 1: twiddle lookup and multiply
  always_comb begin
    pos_d     = beat.first ? '0 : pos_q + 1'b1;  // position restarts each bin
    kn        = beat.bin * pos_d;
    tw_idx    = kn[3:0];                          // (k*n) mod 16
    re_prod_d = $signed(beat.sample) * cos_table[tw_idx];
    im_prod_d = $signed(beat.sample) * sin_table[tw_idx];
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      pos_q      <= '0;
      s1_vld_q   <= 1'b0;
      s1_first_q <= 1'b0;
      s1_last_q  <= 1'b0;
    end else begin
      if (beat.valid) begin
        pos_q <= pos_d;
      end
      s1_vld_q   <= beat.valid;
      s1_first_q <= beat.valid && beat.first;
      s1_last_q  <= beat.valid && beat.last;
    end
  end

  always_ff @(posedge clk) begin
    re_prod_q <= re_prod_d;
    im_prod_q <= im_prod_d;
    s1_bin_q  <= beat.bin;
  end

  // stage 2: accumulate, cleared by first
  assign re_acc_d = s1_first_q ? acc_t'(re_prod_q) : re_acc_q + acc_t'(re_prod_q);
  assign im_acc_d = s1_first_q ? acc_t'(im_prod_q) : im_acc_q + acc_t'(im_prod_q);

  always_ff @(posedge clk) begin
    if (s1_vld_q) begin
      re_acc_q <= re_acc_d;
      im_acc_q <= im_acc_d;
    end
    res_bin_q <= s1_bin_q;
    res_mag_q <= abs_sum_mag(re_acc_d, im_acc_d);  // includes the closing product
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      res_vld_q <= 1'b0;
    end else begin
      res_vld_q <= s1_vld_q && s1_last_q;  // 2 cycles after the last beat
    end
  end

  assign result = '{valid: res_vld_q, bin: res_bin_q, mag: res_mag_q};

endmodule

//--- fft_controller.sv
// frame controller: fills the sample buffer, sweeps bins into the engine, marks frame start/end
`timescale 1ns/1ps

module fft_controller import trigger_fft_types_pkg::*, trigger_fft_ctrl_pkg::*; #(
  parameter int N_POINTS = 16
) (
  input  logic         clk,
  input  logic         reset_b,
  input  logic         data_ready,  // sample strobe
  input  sample_t      sample_rd,   // sample buffer read data
  output logic         wr_en,
  output bin_idx_t     wr_addr,
  output bin_idx_t     rd_addr,
  output sample_beat_t beat,
  output logic         send_frame,  // one pulse per frame start
  output logic         frame_busy,
  output logic         frame_done   // one pulse once the spectrum is complete
);

  localparam bin_idx_t LAST_IDX   = bin_idx_t'(N_POINTS - 1);
  localparam bin_idx_t DRAIN_LAST = bin_idx_t'(3);  // read + two engine stages + write

  ctrl_state_t state_q;
  bin_idx_t    idx_q;         // write index, then sample index, then drain count
  bin_idx_t    bin_q;         // bin under computation
  logic        send_q;
  logic        beat_vld_q;
  logic        beat_first_q;
  logic        beat_last_q;
  bin_idx_t    beat_bin_q;
  logic        fill_done;
  logic        sweep_done;
  logic        drain_done;
  bin_idx_t    idx_inc;

  assign wr_en      = (state_q == IDLE_FILL) && data_ready;  // strobes ignored while busy
  assign wr_addr    = idx_q;
  assign rd_addr    = idx_q;
  assign idx_inc    = (idx_q == LAST_IDX) ? '0 : idx_q + 1'b1;  // wraps at frame size
  assign fill_done  = wr_en && (idx_q == LAST_IDX);
  assign sweep_done = (state_q == TRANSFORM) && (idx_q == LAST_IDX) && (bin_q == LAST_IDX);
  assign drain_done = (state_q == FINISH) && (idx_q == DRAIN_LAST);

  // main FSM and counters
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q <= IDLE_FILL;
      idx_q   <= '0;
      bin_q   <= '0;
      send_q  <= 1'b0;
    end else begin
      send_q <= fill_done;  // start pulse the cycle after the 16th write
      case (state_q)
        IDLE_FILL: begin
          if (wr_en) begin
            idx_q <= idx_inc;  // back to 0 after the last write
          end
          if (fill_done) begin
            state_q <= TRANSFORM;
          end
        end
        TRANSFORM: begin
          idx_q <= idx_inc;  // one sample address per cycle
          if (idx_q == LAST_IDX) begin
            bin_q <= (bin_q == LAST_IDX) ? '0 : bin_q + 1'b1;  // next bin, no gap
          end
          if (sweep_done) begin
            state_q <= FINISH;
          end
        end
        FINISH: begin
          if (drain_done) begin
            idx_q   <= '0;  // next frame writes from 0
            state_q <= IDLE_FILL;
          end else begin
            idx_q <= idx_q + 1'b1;  // drain countdown
          end
        end
        default: state_q <= IDLE_FILL;
      endcase
    end
  end

  // beat flags, delayed to meet the buffer read data
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      beat_vld_q   <= 1'b0;
      beat_first_q <= 1'b0;
      beat_last_q  <= 1'b0;
    end else begin
      beat_vld_q   <= (state_q == TRANSFORM);
      beat_first_q <= (state_q == TRANSFORM) && (idx_q == '0);
      beat_last_q  <= (state_q == TRANSFORM) && (idx_q == LAST_IDX);
    end
  end

  always_ff @(posedge clk) begin
    beat_bin_q <= bin_q;  // qualified by beat_vld_q
  end

  assign beat = '{valid:  beat_vld_q,
                  first:  beat_first_q,
                  last:   beat_last_q,
                  bin:    beat_bin_q,
                  sample: sample_rd};

  assign send_frame = send_q;
  assign frame_busy = (state_q != IDLE_FILL);  // covers transform and drain
  assign frame_done = drain_done;              // cycle after bin 15 lands in the spectrum

endmodule

//--- frame_ram.sv
// frame buffer: one write port, one registered read port, payload type set per instance
`timescale 1ns/1ps

module frame_ram import trigger_fft_types_pkg::*; #(
  parameter type payload_t = sample_t,  // sample_t or mag_t
  parameter int  DEPTH     = 16
) (
  input  logic     clk,
  input  logic     wr_en,
  input  bin_idx_t wr_addr,
  input  payload_t wr_data,
  input  bin_idx_t rd_addr,
  output payload_t rd_data
);

  payload_t mem [DEPTH];  // storage array

  // write side
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;  // last write wins
    end
  end

  // read side, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];  // old data on same-cycle collision
  end

endmodule

//--- tb_trigger_fft.sv
// testbench for the spectral trigger: table-driven frames checked against a reference DFT
`timescale 1ns/1ps

module tb_trigger_fft import trigger_fft_types_pkg::*, trigger_fft_ctrl_pkg::*; ();

  localparam int CLK_NS    = 4;
  localparam int N_ENTRIES = 8;
  localparam int WAIT_MAX  = 400;  // last strobe to spectrum_ready, with margin

  typedef struct packed {
    logic is_rand;   // random samples instead of a tone
    int   tone_bin;
    int   amp;
    int   gap;       // idle cycles between strobes
    int   freq;      // watched bin
    int   ref_bin;   // threshold comes from this bin's model magnitude
    int   ofs;       // added on top of the reference
    logic exp_trig;
    logic junk;      // strobe while busy
  } stim_t;

  // rand, bin, amp, gap, freq, ref, ofs, trig, junk
  localparam stim_t STIM [N_ENTRIES] = '{
    '{1'b0, 1, 400, 0, 1, 1, 0, 1'b1, 1'b0},  // exactly at threshold
    '{1'b0, 1, 400, 2, 1, 1, 1, 1'b0, 1'b0},  // threshold + 1
    '{1'b0, 3, 300, 1, 3, 3, 0, 1'b1, 1'b1},
    '{1'b0, 3, 300, 0, 5, 3, 0, 1'b0, 1'b0},  // same tone, other bin watched
    '{1'b0, 6, 511, 3, 6, 6, 0, 1'b1, 1'b1},
    '{1'b0, 0, 250, 0, 0, 0, 1, 1'b0, 1'b0},  // dc
    '{1'b1, 0, 0,   1, 9, 9, 0, 1'b1, 1'b1},
    '{1'b1, 0, 0,   0, 12, 12, 1, 1'b0, 1'b0}
  };

  logic         clk;
  logic         reset_b;
  logic         data_ready;
  sample_t      sample_in;
  trigger_cfg_t cfg;
  bin_idx_t     spec_addr;
  logic         send_frame;
  logic         frame_busy;
  logic         spectrum_ready;
  logic         trigger;
  mag_t         spec_data;

  int      seed;
  sample_t samples [16];    // frame under test
  int      model_mag [16];  // reference spectrum

  trigger_fft_top #(
    .N_POINTS (16)
  ) dut_i (
    .clk            (clk),
    .reset_b        (reset_b),
    .data_ready     (data_ready),
    .sample_in      (sample_in),
    .cfg            (cfg),
    .spec_addr      (spec_addr),
    .send_frame     (send_frame),
    .frame_busy     (frame_busy),
    .spectrum_ready (spectrum_ready),
    .trigger        (trigger),
    .spec_data      (spec_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic int max_gap();
    int m;
    m = 0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      if (STIM[i].gap > m)
        m = STIM[i].gap;
    end
    return m;
  endfunction

  // watchdog, sized from the table
  initial begin : watchdog
    longint limit_ns;
    limit_ns = longint'(N_ENTRIES) * (16 * max_gap() + 300) * CLK_NS * 2;
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  task automatic step_cycle();
    @(posedge clk);
    #1;  // inputs change and outputs are read here
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  // samples for one entry, then the reference spectrum over them
  task automatic load_frame(input stim_t s);
    int re;
    int im;
    int tw;
    int sum;
    for (int n = 0; n < 16; n++) begin
      if (s.is_rand)
        samples[n] = sample_t'($random(seed));
      else
        samples[n] = sample_t'((s.amp * int'(cos_table[(s.tone_bin * n) % 16])) / 127);
    end
    for (int k = 0; k < 16; k++) begin
      re = 0;
      im = 0;
      for (int n = 0; n < 16; n++) begin
        tw = (k * n) % 16;  // twiddle index
        re += int'(samples[n]) * int'(cos_table[tw]);
        im += int'(samples[n]) * int'(sin_table[tw]);
      end
      re  = (re < 0) ? -re : re;
      im  = (im < 0) ? -im : im;
      sum = (re + im) >>> 7;
      model_mag[k] = (sum > 65535) ? 65535 : sum;  // 16-bit clip
    end
  endtask

  // 16 strobes; nothing may start before the last one
  task automatic deliver_samples(input int gap);
    for (int n = 0; n < 16; n++) begin
      data_ready = 1'b1;
      sample_in  = samples[n];
      step_cycle();
      data_ready = 1'b0;
      check_val("send_frame", 32'(send_frame), 32'(n == 15));
      check_val("frame_busy", 32'(frame_busy), 32'(n == 15));
      check_val("spectrum_ready", 32'(spectrum_ready), 32'd0);
      check_val("trigger", 32'(trigger), 32'd0);
      for (int g = 0; g < gap && n < 15; g++) begin
        step_cycle();
      end
    end
  endtask

  // junk strobes only while busy, so they must be dropped
  task automatic wait_spectrum(input logic junk);
    int cycles;
    cycles = 0;
    while (spectrum_ready !== 1'b1) begin
      check_val("trigger", 32'(trigger), 32'd0);
      data_ready = junk && frame_busy;
      sample_in  = sample_t'($random(seed));
      step_cycle();
      cycles++;
      if (cycles > WAIT_MAX) begin
        $display("spectrum_ready did not arrive within %0d cycles of the frame", WAIT_MAX);
        $display("Verification failed");
        $fatal(1, "no spectrum_ready");
      end
    end
    data_ready = 1'b0;
  endtask

  task automatic read_spectrum();
    for (int k = 0; k < 16; k++) begin
      spec_addr = bin_idx_t'(k);
      step_cycle();  // one cycle read latency
      check_val($sformatf("spec_data[%0d]", k), 32'(spec_data), 32'(model_mag[k]));
    end
  endtask

  initial begin
    int thr;
    seed       = 2174;
    reset_b    = 1'b0;
    data_ready = 1'b0;
    sample_in  = '0;
    cfg        = '0;
    spec_addr  = '0;
    repeat (5) @(posedge clk);
    #1;
    reset_b = 1'b1;
    repeat (3) step_cycle();  // idle, no strobes yet
    check_val("send_frame", 32'(send_frame), 32'd0);
    check_val("frame_busy", 32'(frame_busy), 32'd0);
    check_val("spectrum_ready", 32'(spectrum_ready), 32'd0);
    check_val("trigger", 32'(trigger), 32'd0);
    for (int e = 0; e < N_ENTRIES; e++) begin
      load_frame(STIM[e]);
      thr = model_mag[STIM[e].ref_bin] + STIM[e].ofs;
      cfg.frequency = bin_idx_t'(STIM[e].freq);  // latched at send_frame
      cfg.threshold = mag_t'(thr);
      deliver_samples(STIM[e].gap);
      wait_spectrum(STIM[e].junk);
      check_val("trigger", 32'(trigger), 32'(STIM[e].exp_trig));
      read_spectrum();
    end
    $display("Verification passed");
    $finish;
  end

endmodule

//--- trigger_detect.sv
// trigger detector: watches one bin per frame and fires when it reaches the threshold
`timescale 1ns/1ps

module trigger_detect import trigger_fft_types_pkg::*, trigger_fft_ctrl_pkg::*; (
  input  logic         clk,
  input  logic         reset_b,
  input  trigger_cfg_t cfg,
  input  logic         frame_start,  // latch cfg here
  input  logic         frame_done,   // decide here
  input  bin_result_t  result,
  output logic         trigger
);

  trigger_cfg_t cfg_q;      // config held for the whole frame
  mag_t         hit_mag_q;  // magnitude of the watched bin
  logic         bin_match;
  logic         over_thr;

  assign bin_match = result.valid && (result.bin == cfg_q.frequency);

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      cfg_q     <= '0;
      hit_mag_q <= '0;
    end else begin
      if (frame_start) begin
        cfg_q <= cfg;  // cfg may change freely between frames
      end else if (bin_match) begin
        hit_mag_q <= result.mag;
      end
    end
  end

  assign over_thr = (hit_mag_q >= cfg_q.threshold);  // equal counts as a hit
  assign trigger  = frame_done && over_thr;          // same cycle as spectrum_ready

endmodule

//--- trigger_fft.f
trigger_fft_types_pkg.sv
trigger_fft_ctrl_pkg.sv
frame_ram.sv
fft_controller.sv
dft_engine.sv
trigger_detect.sv
trigger_fft_top.sv
trigger_fft_checker.sv
tb_trigger_fft.sv

//--- trigger_fft_checker.sv
// protocol checker for the spectral trigger top: pulse exclusivity, busy window, reset values
`timescale 1ns/1ps

module trigger_fft_checker (
  input logic clk,
  input logic reset_b,
  input logic send_frame,
  input logic frame_busy,
  input logic spectrum_ready,
  input logic trigger
);

  logic in_frame_q;  // set by send_frame, cleared after spectrum_ready

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      in_frame_q <= 1'b0;
    end else if (send_frame) begin
      in_frame_q <= 1'b1;
    end else if (spectrum_ready) begin
      in_frame_q <= 1'b0;
    end
  end

  a_start_end_apart: assert property (@(posedge clk) disable iff (!reset_b)
    !(send_frame && spectrum_ready))
    else $error("send_frame and spectrum_ready in the same cycle");

  a_trigger_at_end: assert property (@(posedge clk) disable iff (!reset_b)
    trigger |-> spectrum_ready)
    else $error("trigger without spectrum_ready");

  a_busy_window: assert property (@(posedge clk) disable iff (!reset_b)
    (send_frame || in_frame_q) |-> frame_busy)
    else $error("frame_busy low inside a frame");

  a_reset_quiet: assert property (@(posedge clk)
    !reset_b |-> !(send_frame || frame_busy || spectrum_ready || trigger))
    else $error("control output high during reset");

endmodule

bind trigger_fft_top trigger_fft_checker checker_i (
  .clk            (clk),
  .reset_b        (reset_b),
  .send_frame     (send_frame),
  .frame_busy     (frame_busy),
  .spectrum_ready (spectrum_ready),
  .trigger        (trigger)
);

//--- trigger_fft_ctrl_pkg.sv
// spectral trigger control definitions: FSM state encoding and trigger configuration
package trigger_fft_ctrl_pkg;

  import trigger_fft_types_pkg::*;

  // frame sequencing states
  typedef enum logic [1:0] {
    IDLE_FILL = 2'd0,  // collecting samples into the frame buffer
    TRANSFORM = 2'd1,  // sweeping bins x samples into the engine
    FINISH    = 2'd2   // draining the engine pipeline
  } ctrl_state_t;

  // trigger setup, sampled once per frame
  typedef struct packed {
    bin_idx_t frequency;  // bin to watch
    mag_t     threshold;  // trigger when magnitude >= this
  } trigger_cfg_t;

endpackage

//--- trigger_fft_top.sv
// spectral trigger top: sample buffer, frame controller, DFT engine, spectrum buffer, detector
`timescale 1ns/1ps

module trigger_fft_top import trigger_fft_types_pkg::*, trigger_fft_ctrl_pkg::*; #(
  parameter int N_POINTS = 16
) (
  input  logic         clk,
  input  logic         reset_b,
  input  logic         data_ready,      // sample strobe
  input  sample_t      sample_in,
  input  trigger_cfg_t cfg,
  input  bin_idx_t     spec_addr,       // spectrum read address
  output logic         send_frame,      // transform started
  output logic         frame_busy,
  output logic         spectrum_ready,  // all bins written
  output logic         trigger,
  output mag_t         spec_data        // one cycle after spec_addr
);

  logic         samp_wr_en;
  bin_idx_t     samp_wr_addr;
  bin_idx_t     samp_rd_addr;
  sample_t      samp_rd_data;
  sample_beat_t beat;
  bin_result_t  bin_res;
  logic         frame_done;

  fft_controller #(
    .N_POINTS (N_POINTS)
  ) ctrl_i (
    .clk        (clk),
    .reset_b    (reset_b),
    .data_ready (data_ready),
    .sample_rd  (samp_rd_data),
    .wr_en      (samp_wr_en),
    .wr_addr    (samp_wr_addr),
    .rd_addr    (samp_rd_addr),
    .beat       (beat),
    .send_frame (send_frame),
    .frame_busy (frame_busy),
    .frame_done (frame_done)
  );

  frame_ram #(
    .payload_t (sample_t),
    .DEPTH     (N_POINTS)
  ) sample_buf_i (
    .clk     (clk),
    .wr_en   (samp_wr_en),
    .wr_addr (samp_wr_addr),
    .wr_data (sample_in),     // written straight from the input
    .rd_addr (samp_rd_addr),
    .rd_data (samp_rd_data)
  );

  dft_engine engine_i (
    .clk     (clk),
    .reset_b (reset_b),
    .beat    (beat),
    .result  (bin_res)
  );

  frame_ram #(
    .payload_t (mag_t),
    .DEPTH     (N_POINTS)
  ) spectrum_buf_i (
    .clk     (clk),
    .wr_en   (bin_res.valid),  // one write per finished bin
    .wr_addr (bin_res.bin),
    .wr_data (bin_res.mag),
    .rd_addr (spec_addr),
    .rd_data (spec_data)
  );

  trigger_detect detect_i (
    .clk         (clk),
    .reset_b     (reset_b),
    .cfg         (cfg),
    .frame_start (send_frame),
    .frame_done  (frame_done),
    .result      (bin_res),
    .trigger     (trigger)
  );

  assign spectrum_ready = frame_done;

endmodule

//--- trigger_fft_types_pkg.sv
// spectral trigger data formats: samples, twiddles, products, bin results and beats
package trigger_fft_types_pkg;

  typedef logic signed [9:0]  sample_t;   // one input sample, two's complement
  typedef logic [15:0]        mag_t;      // bin magnitude, unsigned
  typedef logic [3:0]         bin_idx_t;  // bin or sample index within a frame
  typedef logic signed [7:0]  twiddle_t;  // cos/sin scaled by 127
  typedef logic signed [17:0] prod_t;     // sample x twiddle
  typedef logic signed [23:0] acc_t;      // sum of 16 products, with headroom

  // one sample on its way into the DFT engine
  typedef struct packed {
    logic     valid;
    logic     first;   // clears the accumulators
    logic     last;    // closes the bin
    bin_idx_t bin;     // bin being computed
    sample_t  sample;
  } sample_beat_t;

  // one finished bin out of the engine
  typedef struct packed {
    logic     valid;
    bin_idx_t bin;
    mag_t     mag;
  } bin_result_t;

  // round(127 * cos(2*pi*m/16))
  localparam twiddle_t cos_table [16] = '{
    8'sd127,  8'sd117,  8'sd90,   8'sd49,   8'sd0,   -8'sd49,  -8'sd90,  -8'sd117,
    -8'sd127, -8'sd117, -8'sd90,  -8'sd49,  8'sd0,    8'sd49,   8'sd90,   8'sd117
  };

  // round(127 * sin(2*pi*m/16))
  localparam twiddle_t sin_table [16] = '{
    8'sd0,    8'sd49,   8'sd90,   8'sd117,  8'sd127,  8'sd117,  8'sd90,   8'sd49,
    8'sd0,    -8'sd49,  -8'sd90,  -8'sd117, -8'sd127, -8'sd117, -8'sd90,  -8'sd49
  };

endpackage
